//--- Bender.yml
package:
  name: decodeStage

sources:
  - files:
      - src/decodePkg.sv
      - src/specifierDecode.sv
      - src/immDecode.sv
      - src/opClassDecode.sv
      - src/prefixLatch.sv
      - src/decodeStage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/decodeStageTb.sv

//--- bench/decodeModel.svh
// Decode reference model
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expects dataW and the decodePkg types in the including module

function automatic decodeCtlT decodedCtl(logic [31:0] w);
	decodeCtlT c;
	opcodeE    op;
	logic      isLd;
	logic      isSt;
	logic      isCb;
	logic      isR2;
	op = opcodeE'(w[6:0]);
	isLd = op inside {LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO};
	isSt = op inside {STB, STW, STT, STO};
	isCb = op inside {JEQ, JNE, JLT, JGE};
	isR2 = (op == R2);
	c = '0;
	c.ra = w[16:12];
	c.rb = w[21:17];
	// Stores carry their data register in the rt field
	c.rc = isSt ? w[11:7] : w[26:22];
	if (!(isSt || isCb || op inside {JMP, BRA, RTS, EXI, NOP}))
		c.rt = w[11:7];
	c.rfWr = isLd || op inside {R2, ADDI, ANDI, ORI, XORI, SLLI, MULI, DIVI};
	if (isCb || op inside {JMP, BRA})
		c.ct = w[8:7];
	c.linkWr = (c.ct != 2'd0);
	if (op == RTS)
		c.ca = w[8:7];
	c.load = isLd;
	c.loadZero = op inside {LDBU, LDWU, LDTU};
	c.store = isSt;
	c.mulUnsigned = isR2 && (w[31:27] == MULU);
	c.mul = (op == MULI) || (isR2 && w[31:27] == MUL) || c.mulUnsigned;
	c.divUnsigned = isR2 && (w[31:27] == DIVU);
	c.div = (op == DIVI) || (isR2 && w[31:27] == DIV) || c.divUnsigned;
	c.jmp = (op == JMP);
	c.condBranch = isCb;
	c.rts = (op == RTS);
	c.flowChange = isCb || op inside {JMP, BRA, RTS};
	if (op inside {LDB, LDBU, STB})
		c.memSize = byt;
	else if (op inside {LDW, LDWU, STW})
		c.memSize = wyde;
	else if (op inside {LDT, LDTU, STT})
		c.memSize = tetra;
	else
		c.memSize = octa;
	return c;
endfunction

function automatic logic [dataW-1:0] extendedImm(logic [31:0] w, logic armed,
	logic [24:0] pfx);
	logic [dataW-1:0] v;
	logic             hasImm;
	opcodeE           op;
	op = opcodeE'(w[6:0]);
	hasImm = 1'b1;
	if (op inside {ADDI, MULI, DIVI, LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO,
		STB, STW, STT, STO})
		v = {{(dataW-15){w[31]}}, w[31:17]};
	else if (op == ANDI)
		v = {{(dataW-15){1'b1}}, w[31:17]};
	else if (op inside {ORI, XORI})
		v = {{(dataW-15){1'b0}}, w[31:17]};
	else if (op == SLLI)
		v = {{(dataW-6){1'b0}}, w[22:17]};
	else
	begin
		v = '0;
		hasImm = 1'b0;
	end
	// 40-bit prefixed constant sign-extended from the prefix top bit
	if (armed && hasImm)
		v = {{(dataW-40){pfx[24]}}, pfx, v[14:0]};
	return v;
endfunction

function automatic logic [dataW-1:0] branchTarget(logic [31:0] w);
	opcodeE op;
	op = opcodeE'(w[6:0]);
	if (op inside {JEQ, JNE, JLT, JGE})
		return {{(dataW-11){w[31]}}, w[31:22], 1'b0};
	else if (op inside {JMP, BRA})
		return {{(dataW-21){w[31]}}, w[31:12], 1'b0};
	return '0;
endfunction

`endif

//--- bench/decodeStageTb.sv
// Decode stage testbench
`timescale 1ns/100ps

module decodeStageTb
	import decodePkg::*;
();

	localparam int dataW = 64;
	localparam int numInstr = 600;
	// Ten cycles per word covers the worst random stalls
	localparam int cycleLimit = numInstr * 10;

	`include "decodeModel.svh"

	typedef struct packed {
		decodeCtlT        ctl;
		logic [dataW-1:0] imm;
		logic [dataW-1:0] tgt;
	} expectT;

	logic             clk;
	logic             rstN;
	logic             inValid;
	logic             inReady;
	instrT            inInstr;
	logic             outValid;
	logic             outReady;
	decodeCtlT        outCtl;
	logic [dataW-1:0] outImm;
	logic [dataW-1:0] outTgt;

	expectT      expQ[$];
	expectT      expHead;
	expectT      nextExp;
	logic        hasExp;
	logic        taken;
	logic        armed;
	logic [24:0] pfxHeld;
	int          errors;
	int          issued;
	int          outCount;
	int          cycles;

	opcodeE opTable[27] = '{R2, ADDI, ANDI, ORI, XORI, SLLI, MULI, DIVI,
		LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO, STB, STW, STT, STO,
		JEQ, JNE, JLT, JGE, JMP, BRA, RTS, NOP};
	funcE funcTable[10] = '{ADD, SUB, AND, OR, XOR, SLL, MUL, MULU, DIV, DIVU};

	decodeStage #(.dataW(dataW)) i_decodeStage (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.outValid(outValid),
		.outReady(outReady),
		.outCtl(outCtl),
		.outImm(outImm),
		.outTgt(outTgt)
	);

	always #50 clk = ~clk;

	// Roughly one word in seven is a prefix
	function automatic logic [31:0] randomWord();
		logic [31:0] w;
		w = $urandom;
		if ($urandom_range(99) < 15)
			w[6:0] = EXI;
		else
		begin
			w[6:0] = opTable[$urandom_range(26)];
			if (w[6:0] == R2)
				w[31:27] = funcTable[$urandom_range(9)];
		end
		return w;
	endfunction

	// ============================================================
	// Model and expected-output queue
	// ============================================================
	always @(posedge clk)
	begin
		if (outValid && outReady && expQ.size() != 0)
		begin
			void'(expQ.pop_front());
			outCount++;
		end
		taken = inValid && inReady;
		if (taken && inInstr.opcode == EXI)
		begin
			armed = 1'b1;
			pfxHeld = inInstr[31:7];
		end
		else if (taken)
		begin
			nextExp.ctl = decodedCtl(inInstr);
			nextExp.imm = extendedImm(inInstr, armed, pfxHeld);
			nextExp.tgt = branchTarget(inInstr);
			expQ.push_back(nextExp);
			armed = 1'b0;
		end
		hasExp = (expQ.size() != 0);
		if (hasExp)
			expHead = expQ[0];
	end

	// ============================================================
	// Checks
	// ============================================================
	checkReset: assert property (@(posedge clk) $rose(rstN) |-> inReady && !outValid)
		else
		begin
			errors++;
			$display("[FAIL] %0t: inReady or outValid wrong after reset", $time);
		end

	checkReady: assert property (@(posedge clk) disable iff (!rstN)
		inReady == (!outValid || outReady))
		else
		begin
			errors++;
			$display("[FAIL] %0t: inReady wrong", $time);
		end

	checkPending: assert property (@(posedge clk) disable iff (!rstN)
		outValid && outReady |-> hasExp)
		else
		begin
			errors++;
			$display("Output delivered with no instruction pending at %0t", $time);
		end

	checkRegs: assert property (@(posedge clk) disable iff (!rstN) outValid && outReady |->
		{outCtl.ra, outCtl.rb, outCtl.rc, outCtl.rt, outCtl.rfWr} ==
		{expHead.ctl.ra, expHead.ctl.rb, expHead.ctl.rc, expHead.ctl.rt, expHead.ctl.rfWr})
		else
		begin
			errors++;
			$display("[FAIL] %0t: register specifiers or rfWr", $time);
		end

	checkLink: assert property (@(posedge clk) disable iff (!rstN) outValid && outReady |->
		{outCtl.ca, outCtl.ct, outCtl.linkWr} ==
		{expHead.ctl.ca, expHead.ctl.ct, expHead.ctl.linkWr})
		else
		begin
			errors++;
			$display("[FAIL] %0t: ca, ct or linkWr", $time);
		end

	checkClass: assert property (@(posedge clk) disable iff (!rstN) outValid && outReady |->
		outCtl == expHead.ctl)
		else
		begin
			errors++;
			$display("[FAIL] %0t: class flags or memSize got %h expected %h",
				$time, $sampled(outCtl), $sampled(expHead.ctl));
		end

	checkImm: assert property (@(posedge clk) disable iff (!rstN) outValid && outReady |->
		outImm == expHead.imm)
		else
		begin
			errors++;
			$display("[FAIL] %0t: outImm got %h expected %h",
				$time, $sampled(outImm), $sampled(expHead.imm));
		end

	checkTgt: assert property (@(posedge clk) disable iff (!rstN) outValid && outReady |->
		outTgt == expHead.tgt)
		else
		begin
			errors++;
			$display("[FAIL] %0t: outTgt got %h expected %h",
				$time, $sampled(outTgt), $sampled(expHead.tgt));
		end

	checkStall: assert property (@(posedge clk) disable iff (!rstN) outValid && !outReady |=>
		outValid && $stable(outCtl) && $stable(outImm) && $stable(outTgt))
		else
		begin
			errors++;
			$display("[FAIL] %0t: output changed while stalled", $time);
		end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	initial
	begin
		void'($urandom(32'h4690cad0));
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		outReady = 1'b0;
		inInstr = '0;
		taken = 1'b0;
		armed = 1'b0;
		pfxHeld = '0;
		hasExp = 1'b0;
		expHead = '0;
		errors = 0;
		issued = 0;
		outCount = 0;
		cycles = 0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;

		// A word stays on the input until it is accepted
		while (issued < numInstr || inValid)
		begin
			@(negedge clk);
			outReady = ($urandom_range(3) != 0);
			if (!inValid || taken)
			begin
				if (issued < numInstr && $urandom_range(3) != 0)
				begin
					inValid = 1'b1;
					inInstr = randomWord();
					issued++;
				end
				else
					inValid = 1'b0;
			end
		end

		outReady = 1'b1;
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);

		if (expQ.size() != 0)
		begin
			errors++;
			$display("%0d expected outputs never came out", expQ.size());
		end
		$display("Summary: %0d words sent, %0d outputs checked, %0d errors",
			issued, outCount, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- src/decodePkg.sv
// Decode stage shared types

package decodePkg;

	// ============================================================
	// Field widths
	// ============================================================
	localparam int prefixW = 25;
	localparam int immW = 15;

	typedef logic [4:0] regNumT;
	typedef logic [1:0] linkNumT;

	// Major opcode in bits 6..0
	typedef enum logic [6:0] {
		NOP  = 7'h00,
		R2   = 7'h02,
		ADDI = 7'h04,
		MULI = 7'h06,
		DIVI = 7'h07,
		ANDI = 7'h08,
		ORI  = 7'h09,
		XORI = 7'h0A,
		SLLI = 7'h0C,
		JMP  = 7'h20,
		BRA  = 7'h21,
		RTS  = 7'h22,
		JEQ  = 7'h26,
		JNE  = 7'h27,
		JLT  = 7'h28,
		JGE  = 7'h29,
		EXI  = 7'h30,
		LDB  = 7'h40,
		LDBU = 7'h41,
		LDW  = 7'h42,
		LDWU = 7'h43,
		LDT  = 7'h44,
		LDTU = 7'h45,
		LDO  = 7'h46,
		STB  = 7'h50,
		STW  = 7'h51,
		STT  = 7'h52,
		STO  = 7'h53
	} opcodeE;

	// Register-register function in bits 31..27
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		SUB  = 5'd1,
		AND  = 5'd2,
		OR   = 5'd3,
		XOR  = 5'd4,
		SLL  = 5'd5,
		MUL  = 5'd8,
		MULU = 5'd9,
		DIV  = 5'd10,
		DIVU = 5'd11
	} funcE;

	typedef enum logic [1:0] {
		byt   = 2'd0,
		wyde  = 2'd1,
		tetra = 2'd2,
		octa  = 2'd3
	} memSizeE;

	// ============================================================
	// Instruction layout
	// ============================================================
	typedef struct packed {
		funcE   func;
		regNumT rc;
		regNumT rb;
		regNumT ra;
		regNumT rt;
		opcodeE opcode;
	} instrT;

	// Overlays on the same word
	function automatic logic [immW-1:0] imm15Of(instrT i);
		return i[31:17];
	endfunction

	function automatic logic [5:0] shamtOf(instrT i);
		return i[22:17];
	endfunction

	function automatic logic [9:0] brDisp10Of(instrT i);
		return i[31:22];
	endfunction

	function automatic logic [19:0] jmpDisp20Of(instrT i);
		return i[31:12];
	endfunction

	function automatic logic [prefixW-1:0] pfx25Of(instrT i);
		return i[31:7];
	endfunction

	// Link field shares the low bits of rt
	function automatic linkNumT lkOf(instrT i);
		return i[8:7];
	endfunction

	// Decoded control word
	typedef struct packed {
		regNumT  ra;
		regNumT  rb;
		regNumT  rc;
		regNumT  rt;
		linkNumT ca;
		linkNumT ct;
		logic    rfWr;
		logic    linkWr;
		logic    load;
		logic    loadZero;
		logic    store;
		logic    mul;
		logic    mulUnsigned;
		logic    div;
		logic    divUnsigned;
		logic    jmp;
		logic    condBranch;
		logic    rts;
		logic    flowChange;
		memSizeE memSize;
	} decodeCtlT;

endpackage

//--- src/decodeStage.sv
// Instruction decode stage
`timescale 1ns/100ps

module decodeStage
	import decodePkg::*;
#(
	parameter int dataW = 64
)
(
	input  logic             clk,
	input  logic             rstN,
	input  logic             inValid,
	output logic             inReady,
	input  instrT            inInstr,
	output logic             outValid,
	input  logic             outReady,
	output decodeCtlT        outCtl,
	output logic [dataW-1:0] outImm,
	output logic [dataW-1:0] outTgt
);

	decodeCtlT          ctlNext;
	logic [dataW-1:0]   immNext;
	logic [dataW-1:0]   tgtNext;
	logic               pfxValid;
	logic [prefixW-1:0] pfxBits;
	logic               take;
	logic               load;

	// ============================================================
	// Handshake
	// ============================================================
	assign inReady = !outValid || outReady;
	assign take = inValid && inReady;

	// Prefix words only arm the latch
	assign load = take && (inInstr.opcode != EXI);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else if (load)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			outCtl <= ctlNext;
			outImm <= immNext;
			outTgt <= tgtNext;
		end
	end

	// ============================================================
	// Decoders
	// ============================================================
	specifierDecode i_specifierDecode (
		.instr(inInstr),
		.ra(ctlNext.ra),
		.rb(ctlNext.rb),
		.rc(ctlNext.rc),
		.rt(ctlNext.rt),
		.ca(ctlNext.ca),
		.ct(ctlNext.ct),
		.rfWr(ctlNext.rfWr),
		.linkWr(ctlNext.linkWr)
	);

	opClassDecode i_opClassDecode (
		.instr(inInstr),
		.load(ctlNext.load),
		.loadZero(ctlNext.loadZero),
		.store(ctlNext.store),
		.mul(ctlNext.mul),
		.mulUnsigned(ctlNext.mulUnsigned),
		.div(ctlNext.div),
		.divUnsigned(ctlNext.divUnsigned),
		.jmp(ctlNext.jmp),
		.condBranch(ctlNext.condBranch),
		.rts(ctlNext.rts),
		.flowChange(ctlNext.flowChange),
		.memSize(ctlNext.memSize)
	);

	immDecode #(.dataW(dataW)) i_immDecode (
		.instr(inInstr),
		.pfxValid(pfxValid),
		.pfxBits(pfxBits),
		.imm(immNext),
		.tgt(tgtNext)
	);

	prefixLatch i_prefixLatch (
		.clk(clk),
		.rstN(rstN),
		.instr(inInstr),
		.take(take),
		.pfxValid(pfxValid),
		.pfxBits(pfxBits)
	);

	// Stalled output holds still until the consumer takes it
	assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outCtl)
			&& $stable(outImm) && $stable(outTgt));

endmodule

//--- src/immDecode.sv
// Immediate and branch target decode
`timescale 1ns/100ps

module immDecode
	import decodePkg::*;
#(
	parameter int dataW = 64
)
(
	input  instrT              instr,
	input  logic               pfxValid,
	input  logic [prefixW-1:0] pfxBits,
	output logic [dataW-1:0]   imm,
	output logic [dataW-1:0]   tgt
);

	localparam int extW = prefixW + immW;

	logic [immW-1:0]        imm15;
	logic [dataW-1:0]       baseImm;
	logic                   hasImm;
	logic signed [extW-1:0] extImm;
	logic signed [10:0]     brOff;
	logic signed [20:0]     jmpOff;

	// The prefix needs room above the immediate
	if (dataW < extW)
	begin : gWidthCheck
		$error("immDecode needs dataW of at least %0d", extW);
	end

	assign imm15 = imm15Of(instr);

	// ============================================================
	// Immediate before any prefix
	// ============================================================
	always_comb
	begin
		hasImm = 1'b1;
		case (instr.opcode)
			ADDI, MULI, DIVI,
			LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO,
			STB, STW, STT, STO:
				baseImm = {{(dataW-immW){imm15[immW-1]}}, imm15};
			// Ones to the left keep the upper bits of the operand
			ANDI:
				baseImm = {{(dataW-immW){1'b1}}, imm15};
			ORI, XORI:
				baseImm = {{(dataW-immW){1'b0}}, imm15};
			SLLI:
				baseImm = {{(dataW-6){1'b0}}, shamtOf(instr)};
			default:
			begin
				baseImm = '0;
				hasImm = 1'b0;
			end
		endcase
	end

	// Prefix bits go above the low immediate bits
	assign extImm = {pfxBits, baseImm[immW-1:0]};
	assign imm = (pfxValid && hasImm) ? dataW'(extImm) : baseImm;

	// ============================================================
	// Branch target
	// ============================================================
	assign brOff = {brDisp10Of(instr), 1'b0};
	assign jmpOff = {jmpDisp20Of(instr), 1'b0};

	always_comb
	begin
		case (instr.opcode)
			JEQ, JNE, JLT, JGE:
				tgt = dataW'(brOff);
			JMP, BRA:
				tgt = dataW'(jmpOff);
			default:
				tgt = '0;
		endcase
	end

endmodule

//--- src/opClassDecode.sv
// Operation class decode
`timescale 1ns/100ps

module opClassDecode
	import decodePkg::*;
(
	input  instrT   instr,
	output logic    load,
	output logic    loadZero,
	output logic    store,
	output logic    mul,
	output logic    mulUnsigned,
	output logic    div,
	output logic    divUnsigned,
	output logic    jmp,
	output logic    condBranch,
	output logic    rts,
	output logic    flowChange,
	output memSizeE memSize
);

	logic isR2;
	logic isBra;

	assign isR2 = (instr.opcode == R2);
	assign isBra = (instr.opcode == BRA);

	// ============================================================
	// Memory operations
	// ============================================================
	assign load = instr.opcode inside {LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO};
	assign loadZero = instr.opcode inside {LDBU, LDWU, LDTU};
	assign store = instr.opcode inside {STB, STW, STT, STO};

	// Size follows the suffix letter
	always_comb
	begin
		case (instr.opcode)
			LDB, LDBU, STB:
				memSize = byt;
			LDW, LDWU, STW:
				memSize = wyde;
			LDT, LDTU, STT:
				memSize = tetra;
			default:
				memSize = octa;
		endcase
	end

	// ============================================================
	// Multi-cycle arithmetic
	// ============================================================
	always_comb
	begin
		mul = (instr.opcode == MULI);
		mulUnsigned = 1'b0;
		div = (instr.opcode == DIVI);
		divUnsigned = 1'b0;
		if (isR2)
		begin
			case (instr.func)
				MUL:
					mul = 1'b1;
				MULU:
				begin
					mul = 1'b1;
					mulUnsigned = 1'b1;
				end
				DIV:
					div = 1'b1;
				DIVU:
				begin
					div = 1'b1;
					divUnsigned = 1'b1;
				end
				default:
					mul = 1'b0;
			endcase
		end
	end

	// Flow control
	assign jmp = (instr.opcode == JMP);
	assign condBranch = instr.opcode inside {JEQ, JNE, JLT, JGE};
	assign rts = (instr.opcode == RTS);
	assign flowChange = jmp | isBra | condBranch | rts;

	// A word is either a load or a store, never both
	assert final (!(load && store));

endmodule

//--- src/prefixLatch.sv
// Constant prefix holding register
`timescale 1ns/100ps

module prefixLatch
	import decodePkg::*;
(
	input  logic               clk,
	input  logic               rstN,
	input  instrT              instr,
	input  logic               take,
	output logic               pfxValid,
	output logic [prefixW-1:0] pfxBits
);

	logic isPrefix;

	assign isPrefix = (instr.opcode == EXI);

	// Armed by a prefix and spent by whatever comes next
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pfxValid <= 1'b0;
		end
		else if (take)
		begin
			pfxValid <= isPrefix;
		end
	end

	// A second prefix simply overwrites the first
	always_ff @(posedge clk)
	begin
		if (take && isPrefix)
		begin
			pfxBits <= pfx25Of(instr);
		end
	end

	// Nothing is armed coming out of reset
	assert property (@(posedge clk) $rose(rstN) |-> !pfxValid);

endmodule

//--- src/specifierDecode.sv
// Register specifier decode
`timescale 1ns/100ps

module specifierDecode
	import decodePkg::*;
(
	input  instrT   instr,
	output regNumT  ra,
	output regNumT  rb,
	output regNumT  rc,
	output regNumT  rt,
	output linkNumT ca,
	output linkNumT ct,
	output logic    rfWr,
	output logic    linkWr
);

	logic    isStore;
	linkNumT lk;

	assign lk = lkOf(instr);
	assign isStore = instr.opcode inside {STB, STW, STT, STO};

	// Sources come straight from their fields
	assign ra = instr.ra;
	assign rb = instr.rb;

	// Store data sits in the rt field
	assign rc = isStore ? instr.rt : instr.rc;

	always_comb
	begin
		case (instr.opcode)
			STB, STW, STT, STO:
				rt = '0;
			JEQ, JNE, JLT, JGE:
				rt = '0;
			JMP, BRA, RTS, EXI, NOP:
				rt = '0;
			default:
				rt = instr.rt;
		endcase
	end

	always_comb
	begin
		case (instr.opcode)
			R2, ADDI, ANDI, ORI, XORI, SLLI, MULI, DIVI:
				rfWr = 1'b1;
			LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO:
				rfWr = 1'b1;
			default:
				rfWr = 1'b0;
		endcase
	end

	// Link register target for calls and branches
	always_comb
	begin
		ct = '0;
		ca = '0;
		case (instr.opcode)
			JMP, BRA, JEQ, JNE, JLT, JGE:
				ct = lk;
			RTS:
				ca = lk;
			default:
				ct = '0;
		endcase
	end

	// Link zero is never written
	assign linkWr = (ct != '0);

endmodule

//--- tb.f
+incdir+bench
src/decodePkg.sv
src/specifierDecode.sv
src/immDecode.sv
src/opClassDecode.sv
src/prefixLatch.sv
src/decodeStage.sv
bench/decodeStageTb.sv
